/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int wordWidth = 24;                      // data, instruction and pc width

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [3:0]           regAddrT;

    // instruction field positions
    localparam int opcodeMsb = 23;
    localparam int opcodeLsb = 21;
    localparam int vBit      = 20;
    localparam int rdMsb     = 19;
    localparam int rdLsb     = 16;
    localparam int rsMsb     = 15;
    localparam int rsLsb     = 12;
    localparam int rtMsb     = 11;
    localparam int rtLsb     = 8;
    localparam int immMsb    = 7;                       // five-bit alu immediate
    localparam int immLsb    = 3;
    localparam int offsetMsb = 7;                       // memory offset, down to bit 0
    localparam int targetMsb = 19;                      // branch target, down to bit 0
    localparam int functMsb  = 2;
    localparam int functLsb  = 0;

    typedef enum logic [2:0] {
        opData       = 3'b000,
        opLoad       = 3'b001,
        opStore      = 3'b010,
        opBranch     = 3'b011,
        opBranchZero = 3'b100
    } opcodeT;                                          // 101..111 act as nop

    typedef enum logic [1:0] {
        immAlu    = 2'b00,
        immMem    = 2'b01,
        immBranch = 2'b10
    } immSrcT;

endpackage

`default_nettype wire

/* source/aluPkg.sv */
`default_nettype none

package aluPkg;

    // encoding matches the funct field
    typedef enum logic [2:0] {
        aluAdd   = 3'b000,
        aluSub   = 3'b001,
        aluAnd   = 3'b010,
        aluOr    = 3'b011,
        aluXor   = 3'b100,
        aluShl   = 3'b101,
        aluShr   = 3'b110,
        aluPassB = 3'b111
    } aluOpT;

    localparam int shiftAmtWidth = 5;                   // shift amount taken from b

    typedef logic [3:0] flagsT;

    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;                           // no borrow on sub
    localparam int flagV = 0;

endpackage

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, aluPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  opcodeT opcode,
    input  logic   v,
    input  aluOpT  funct,
    input  flagsT  aluFlags,
    output logic   pcSrc,
    output logic   memToReg,
    output logic   memWrite,
    output logic   aluSrc,
    output logic   regWrite,
    output aluOpT  aluControl,
    output immSrcT immSrc
);

    logic  regWriteDec;
    logic  memWriteDec;
    logic  flagWrite;
    flagsT flagsQ;

    always_comb begin
        pcSrc       = 1'b0;
        memToReg    = 1'b0;
        memWriteDec = 1'b0;
        aluSrc      = 1'b0;
        regWriteDec = 1'b0;
        flagWrite   = 1'b0;
        aluControl  = aluAdd;
        immSrc      = immAlu;
        case (opcode)
            opData: begin
                aluSrc      = v;                        // v picks the immediate
                aluControl  = funct;
                regWriteDec = 1'b1;
                flagWrite   = 1'b1;
            end
            opLoad: begin
                aluSrc      = 1'b1;
                immSrc      = immMem;
                memToReg    = 1'b1;
                regWriteDec = 1'b1;
            end
            opStore: begin
                aluSrc      = 1'b1;
                immSrc      = immMem;
                memWriteDec = 1'b1;
            end
            opBranch: begin
                aluSrc     = 1'b1;
                immSrc     = immBranch;
                aluControl = aluPassB;                  // result is the target
                pcSrc      = 1'b1;
            end
            opBranchZero: begin
                aluSrc     = 1'b1;
                immSrc     = immBranch;
                aluControl = aluPassB;
                pcSrc      = flagsQ[flagZ];             // stored z from last data op
            end
            default: begin
            end
        endcase
    end

    // no writes of any kind while the program is being loaded
    assign regWrite = regWriteDec & arstN;
    assign memWrite = memWriteDec & arstN;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flagsQ <= '0;
        end else if (flagWrite) begin
            flagsQ <= aluFlags;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) !(memWrite && regWrite));

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import isaPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  regAddrT readAddr1,
    input  regAddrT readAddr2,
    input  regAddrT writeAddr,
    input  logic    writeEn,
    input  wordT    writeData,
    output wordT    readData1,
    output wordT    readData2
);

    localparam int numRegs = 2 ** $bits(regAddrT);

    wordT regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1];                 // base / operand a
    assign readData2 = regs[readAddr2];                 // rt, also store data

endmodule

`default_nettype wire

/* source/immExtend.sv */
`timescale 1ns/1ps
`default_nettype none

module immExtend import isaPkg::*; (
    input  wordT   instruction,
    input  immSrcT immSrc,
    output wordT   extImm
);

    always_comb begin
        case (immSrc)
            immAlu:    extImm = wordT'(instruction[immMsb:immLsb]);
            immMem:    extImm = wordT'(instruction[offsetMsb:0]);
            immBranch: extImm = wordT'(instruction[targetMsb:0]);  // absolute target
            default:   extImm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import isaPkg::*, aluPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpT aluControl,
    output wordT  result,
    output flagsT flags
);

    logic [wordWidth:0]       addFull;
    logic [wordWidth:0]       subFull;
    logic [shiftAmtWidth-1:0] shiftAmt;
    logic                     carryOut;
    logic                     overflow;

    assign addFull  = {1'b0, a} + {1'b0, b};
    assign subFull  = {1'b0, a} + {1'b0, ~b} + 1'b1;    // carry out means no borrow
    assign shiftAmt = b[shiftAmtWidth-1:0];

    always_comb begin
        carryOut = 1'b0;
        overflow = 1'b0;
        case (aluControl)
            aluAdd: begin
                result   = addFull[wordWidth-1:0];
                carryOut = addFull[wordWidth];
                overflow = (a[wordWidth-1] == b[wordWidth-1]) &&
                           (addFull[wordWidth-1] != a[wordWidth-1]);
            end
            aluSub: begin
                result   = subFull[wordWidth-1:0];
                carryOut = subFull[wordWidth];
                overflow = (a[wordWidth-1] != b[wordWidth-1]) &&
                           (subFull[wordWidth-1] != a[wordWidth-1]);
            end
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluShl:   result = a << shiftAmt;
            aluShr:   result = a >> shiftAmt;           // logical
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign flags[flagN] = result[wordWidth-1];
    assign flags[flagZ] = (result == '0);
    assign flags[flagC] = carryOut;
    assign flags[flagV] = overflow;

endmodule

`default_nettype wire

/* source/instrMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMemory import isaPkg::*; #(
    parameter int imemAddrWidth = 8
) (
    input  logic clk,
    input  wordT addr,                                  // pc
    input  logic loadEn,
    input  wordT loadAddr,
    input  wordT loadData,
    output wordT rdata
);

    localparam int depth = 2 ** imemAddrWidth;

    wordT mem [depth];

    // program load port, used while the core is held in reset
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr[imemAddrWidth-1:0]] <= loadData;
        end
    end

    assign rdata = mem[addr[imemAddrWidth-1:0]];        // low pc bits only

endmodule

`default_nettype wire

/* source/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMemory import isaPkg::*; #(
    parameter int dmemAddrWidth = 8
) (
    input  logic clk,
    input  logic writeEn,
    input  wordT addr,
    input  wordT wdata,
    output wordT rdata
);

    localparam int depth = 2 ** dmemAddrWidth;

    wordT mem [depth];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr[dmemAddrWidth-1:0]] <= wdata;      // written at end of the store cycle
        end
    end

    // same-cycle read for loads
    assign rdata = mem[addr[dmemAddrWidth-1:0]];

endmodule

`default_nettype wire

/* source/processor.sv */
`timescale 1ns/1ps
`default_nettype none

module processor import isaPkg::*, aluPkg::*; (
    input  logic clk,
    input  logic arstN,
    input  wordT instruction,                           // from instruction memory
    input  wordT readData,                              // from data memory
    output wordT pcAddress,
    output logic memWrite,
    output wordT aluResult,                             // data address on loads/stores
    output wordT writeData
);

    opcodeT  opcode;
    logic    v;
    regAddrT rd;
    regAddrT rs;
    regAddrT rt;
    aluOpT   funct;

    logic    pcSrc;
    logic    memToReg;
    logic    aluSrc;
    logic    regWrite;
    aluOpT   aluControl;
    immSrcT  immSrc;
    flagsT   aluFlags;

    wordT    srcA;
    wordT    rtData;
    wordT    srcB;
    wordT    extImm;
    wordT    result;
    wordT    pcPlus1;
    wordT    nextPc;

    // field split
    assign opcode = opcodeT'(instruction[opcodeMsb:opcodeLsb]);
    assign v      = instruction[vBit];
    assign rd     = instruction[rdMsb:rdLsb];
    assign rs     = instruction[rsMsb:rsLsb];
    assign rt     = instruction[rtMsb:rtLsb];
    assign funct  = aluOpT'(instruction[functMsb:functLsb]);

    assign pcPlus1 = pcAddress + wordT'(1);
    assign nextPc  = pcSrc ? result : pcPlus1;          // branch target comes via alu

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcAddress <= '0;
        end else begin
            pcAddress <= nextPc;
        end
    end

    controlUnit u_controlUnit (
        .clk        (clk),
        .arstN      (arstN),
        .opcode     (opcode),
        .v          (v),
        .funct      (funct),
        .aluFlags   (aluFlags),
        .pcSrc      (pcSrc),
        .memToReg   (memToReg),
        .memWrite   (memWrite),
        .aluSrc     (aluSrc),
        .regWrite   (regWrite),
        .aluControl (aluControl),
        .immSrc     (immSrc)
    );

    registerFile u_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .readAddr1 (rs),
        .readAddr2 (rt),                                // rt for data ops and stores
        .writeAddr (rd),
        .writeEn   (regWrite),
        .writeData (result),
        .readData1 (srcA),
        .readData2 (rtData)
    );

    immExtend u_immExtend (
        .instruction (instruction),
        .immSrc      (immSrc),
        .extImm      (extImm)
    );

    assign srcB      = aluSrc ? extImm : rtData;
    assign writeData = rtData;                          // store writes rt

    alu u_alu (
        .a          (srcA),
        .b          (srcB),
        .aluControl (aluControl),
        .result     (aluResult),
        .flags      (aluFlags)
    );

    assign result = memToReg ? readData : aluResult;

    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(pcAddress));

    // sub gives z exactly when the operands match
    assert property (@(posedge clk) disable iff (!arstN)
        (aluControl == aluSub) |-> (aluFlags[flagZ] == (srcA == srcB)));

endmodule

`default_nettype wire

/* source/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop import isaPkg::*; #(
    parameter int imemAddrWidth = 8,
    parameter int dmemAddrWidth = 8
) (
    input  logic clk,
    input  logic arstN,
    input  logic loadEn,                                // program load, under reset only
    input  wordT loadAddr,
    input  wordT loadData,
    output wordT pcAddress,
    output logic memWrite,
    output wordT memAddr,
    output wordT memWriteData
);

    wordT instruction;
    wordT readData;

    processor u_processor (
        .clk         (clk),
        .arstN       (arstN),
        .instruction (instruction),
        .readData    (readData),
        .pcAddress   (pcAddress),
        .memWrite    (memWrite),
        .aluResult   (memAddr),
        .writeData   (memWriteData)
    );

    instrMemory #(
        .imemAddrWidth (imemAddrWidth)
    ) u_instrMemory (
        .clk      (clk),
        .addr     (pcAddress),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdata    (instruction)
    );

    dataMemory #(
        .dmemAddrWidth (dmemAddrWidth)
    ) u_dataMemory (
        .clk     (clk),
        .writeEn (memWrite),
        .addr    (memAddr),
        .wdata   (memWriteData),
        .rdata   (readData)
    );

endmodule

`default_nettype wire

/* sim/cpuTests.svh */
`default_nettype none

function automatic wordT encData(aluOpT f, logic v, regAddrT rd, regAddrT rs, regAddrT rt,
                                 logic [4:0] imm);
    return {opData, v, rd, rs, rt, imm, f};
endfunction

function automatic wordT encMem(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt,
                                logic [7:0] offset);
    return {op, 1'b0, rd, rs, rt, offset};            // rd for loads, rt for stores
endfunction

function automatic wordT encBranch(opcodeT op, logic [19:0] target);
    return {op, 1'b0, target};
endfunction

// expected result of each alu operation
function automatic wordT aluModel(aluOpT op, wordT a, wordT b);
    case (op)
        aluAdd:  return a + b;
        aluSub:  return a - b;
        aluAnd:  return a & b;
        aluOr:   return a | b;
        aluXor:  return a ^ b;
        aluShl:  return a << b[4:0];
        aluShr:  return a >> b[4:0];
        default: return b;
    endcase
endfunction

task automatic startProgram();
    prog     = {};
    expAddrQ = {};
    expDataQ = {};
endtask

task automatic expectStore(input wordT addr, input wordT data);
    expAddrQ.push_back(addr);
    expDataQ.push_back(data);
endtask

// r = {hi, 14'b0, lo} in three instructions
task automatic addOperand(input regAddrT r, input logic [4:0] hi, input logic [4:0] lo);
    prog.push_back(encData(aluAdd, 1'b1, r, 4'd0, 4'd0, hi));
    prog.push_back(encData(aluShl, 1'b1, r, r, 4'd0, 5'd19));
    prog.push_back(encData(aluOr, 1'b1, r, r, 4'd0, lo));
endtask

task automatic testRegisterOps();
    logic [4:0] aHi, aLo, bHi, bLo;
    aluOpT      op;
    for (int f = 0; f < 8; f++) begin
        op  = aluOpT'(f);
        aHi = 5'($random(seed));
        aLo = 5'($random(seed));
        bHi = 5'($random(seed));
        bLo = 5'($random(seed));
        startProgram();
        addOperand(4'd1, aHi, aLo);
        addOperand(4'd2, bHi, bLo);
        prog.push_back(encData(op, 1'b0, 4'd3, 4'd1, 4'd2, 5'd0));
        prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd3, 8'(f)));
        prog.push_back(encBranch(opBranch, 20'd8));          // halt
        expectStore(wordT'(f), aluModel(op, {aHi, 14'b0, aLo}, {bHi, 14'b0, bLo}));
        loadProgram();
        runToHalt(wordT'(8));
        checkStores($sformatf("register op %s", op.name()));
    end
endtask

task automatic testImmediateOps();
    logic [4:0] aHi, aLo, i1, i2, i3;
    wordT       a;
    aHi = 5'($random(seed));
    aLo = 5'($random(seed));
    i1  = 5'($random(seed));
    i2  = 5'($random(seed));
    i3  = 5'($random(seed));
    a   = {aHi, 14'b0, aLo};
    startProgram();
    addOperand(4'd1, aHi, aLo);
    prog.push_back(encData(aluAdd, 1'b1, 4'd2, 4'd1, 4'd0, i1));
    prog.push_back(encData(aluAnd, 1'b1, 4'd3, 4'd1, 4'd0, i2));
    prog.push_back(encData(aluXor, 1'b1, 4'd4, 4'd1, 4'd0, i3));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd2, 8'h10));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd3, 8'h11));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd4, 8'h12));
    prog.push_back(encBranch(opBranch, 20'd9));
    expectStore(24'h10, aluModel(aluAdd, a, wordT'(i1)));
    expectStore(24'h11, aluModel(aluAnd, a, wordT'(i2)));
    expectStore(24'h12, aluModel(aluXor, a, wordT'(i3)));
    loadProgram();
    runToHalt(wordT'(9));
    checkStores("immediate ops");
endtask

task automatic testMemRoundTrip();
    logic [4:0] base, hi, lo;
    logic [7:0] off1, off2;
    base = 5'($random(seed));
    hi   = 5'($random(seed));
    lo   = 5'($random(seed));
    off1 = 8'($random(seed));
    off2 = off1 ^ 8'h80;                               // another data word
    startProgram();
    prog.push_back(encData(aluAdd, 1'b1, 4'd1, 4'd0, 4'd0, base));
    addOperand(4'd2, hi, lo);
    prog.push_back(encMem(opStore, 4'd0, 4'd1, 4'd2, off1));
    prog.push_back(encMem(opLoad, 4'd3, 4'd1, 4'd0, off1));
    prog.push_back(encMem(opStore, 4'd0, 4'd1, 4'd3, off2));
    prog.push_back(encBranch(opBranch, 20'd7));
    expectStore(wordT'(base) + wordT'(off1), {hi, 14'b0, lo});
    expectStore(wordT'(base) + wordT'(off2), {hi, 14'b0, lo});
    loadProgram();
    runToHalt(wordT'(7));
    checkStores("store load round trip");
endtask

task automatic testBranches();
    logic [4:0] k;
    k = 5'($random(seed)) | 5'd1;                      // nonzero
    startProgram();
    prog.push_back(encData(aluAdd, 1'b1, 4'd1, 4'd0, 4'd0, k));
    prog.push_back(encBranch(opBranch, 20'd3));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd1, 8'h10));   // skipped
    prog.push_back(encData(aluSub, 1'b0, 4'd2, 4'd1, 4'd1, 5'd0));
    prog.push_back(encBranch(opBranchZero, 20'd6));            // taken
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd1, 8'h11));   // skipped
    prog.push_back(encData(aluSub, 1'b0, 4'd2, 4'd1, 4'd0, 5'd0));
    prog.push_back(encBranch(opBranchZero, 20'd9));            // not taken
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd1, 8'h12));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd1, 8'h13));
    prog.push_back(encBranch(opBranch, 20'd10));
    expectStore(24'h12, wordT'(k));
    expectStore(24'h13, wordT'(k));
    loadProgram();
    runToHalt(wordT'(10));
    checkStores("branches");
endtask

// stores seen while counting are kept for checkStores
task automatic countFromZero(input string name);
    for (int i = 0; i < 3; i++) begin
        @(negedge clk);
        checkPc(name, wordT'(i), pcAddress);
        if (memWrite) begin
            storeAddrQ.push_back(memAddr);
            storeDataQ.push_back(memWriteData);
        end
    end
endtask

task automatic testReset();
    logic [4:0] k1, k2;
    k1 = 5'($random(seed));
    k2 = 5'($random(seed));
    startProgram();
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd0, 8'h1f));   // sits at pc 0 during reset
    prog.push_back(encData(aluAdd, 1'b1, 4'd1, 4'd0, 4'd0, k1));
    prog.push_back(encData(aluAdd, 1'b1, 4'd1, 4'd1, 4'd0, k2));
    prog.push_back(encData(aluOr, 1'b1, 4'd2, 4'd1, 4'd0, 5'd0));
    prog.push_back(encMem(opStore, 4'd0, 4'd0, 4'd2, 8'h20));
    prog.push_back(encBranch(opBranch, 20'd5));
    expectStore(24'h1f, '0);
    expectStore(24'h20, wordT'(k1) + wordT'(k2));
    loadProgram();
    countFromZero("pc after release");
    loadProgram();                                     // reset in the middle of the run
    countFromZero("pc after mid-run reset");
    runToHalt(wordT'(5));
    checkStores("reset restart");
endtask

`default_nettype wire

/* sim/cpuTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb import isaPkg::*, aluPkg::*; ();

    localparam int clkPeriod      = 40;
    localparam int resetCycles    = 16;
    localparam int numLoads       = 13;                 // program loads over all tests
    localparam int maxProgLen     = 16;
    localparam int watchdogCycles = numLoads * (maxProgLen + resetCycles + 64);

    logic clk = 1'b0;
    logic arstN;
    logic loadEn;
    wordT loadAddr;
    wordT loadData;
    wordT pcAddress;
    logic memWrite;
    wordT memAddr;
    wordT memWriteData;

    wordT   prog[$];                                    // program of the current test
    wordT   storeAddrQ[$], storeDataQ[$];               // stores seen on the bus
    wordT   expAddrQ[$], expDataQ[$];
    integer seed = 10;

    cpuTop dut (
        .clk          (clk),
        .arstN        (arstN),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .pcAddress    (pcAddress),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkPc(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s pc expected %h actual %h", name, expected, actual));
        end
    endtask

    // holds reset for 16 cycles and writes the program one word per edge
    task automatic loadProgram();
        @(posedge clk);
        arstN <= 1'b0;
        for (int i = 0; i < resetCycles; i++) begin
            loadEn   <= (i < prog.size());
            loadAddr <= wordT'(i);
            loadData <= (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
            checkPc("reset hold", '0, pcAddress);
            if (memWrite !== 1'b0) begin
                failRun("memWrite was not low while the program was loading");
            end
            @(posedge clk);
        end
        arstN      <= 1'b1;
        loadEn     <= 1'b0;
        storeAddrQ = {};
        storeDataQ = {};
    endtask

    // collects stores until the pc sits on the halt branch
    task automatic runToHalt(input wordT haltAddr);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (memWrite) begin
                storeAddrQ.push_back(memAddr);
                storeDataQ.push_back(memWriteData);
            end
            done = (pcAddress == haltAddr);
        end
    endtask

    task automatic checkStores(input string name);
        if (storeAddrQ.size() != expAddrQ.size()) begin
            failRun($sformatf("[FAIL] %s expected %0d stores actual %0d", name,
                              expAddrQ.size(), storeAddrQ.size()));
        end
        for (int i = 0; i < expAddrQ.size(); i++) begin
            checkWord({name, " address"}, expAddrQ[i], storeAddrQ[i]);
            checkWord({name, " data"}, expDataQ[i], storeDataQ[i]);
        end
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        failRun("timeout, a program never reached its halt address");
    end

    initial begin
        arstN    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        testRegisterOps();
        testImmediateOps();
        testMemRoundTrip();
        testBranches();
        testReset();
        $display("Regression passed");
        $finish;
    end

    `include "cpuTests.svh"

endmodule

`default_nettype wire

/* cpuTop.f */
+incdir+sim
source/isaPkg.sv
source/aluPkg.sv
source/controlUnit.sv
source/registerFile.sv
source/immExtend.sv
source/alu.sv
source/instrMemory.sv
source/dataMemory.sv
source/processor.sv
source/cpuTop.sv
sim/cpuTopTb.sv
